//--- common/hba_pkg.sv
// Shared HBA types and constants. The address map assumes 16 slots of 256 byte-wide registers.
package hba_pkg;

    // Bus widths.
    typedef logic [7:0]  dbus_t;      // Bus data byte.
    typedef logic [11:0] abus_t;      // Slot nibble plus register offset.
    typedef logic [3:0]  slot_t;      // Upper address nibble.
    typedef logic [7:0]  reg_addr_t;  // Offset inside a slot.
    typedef logic [3:0]  gpio_t;      // GPIO pin vector.

    // Bridge FSM encoding.
    typedef enum logic [1:0] {
        ST_IDLE,  // Waiting for a host command.
        ST_BUS,   // Transfer on the bus.
        ST_RESP   // Holding the response for the host.
    } bridge_state_t;

    // Slot map.
    localparam slot_t SLOT_BASICIO = 4'd1;
    localparam slot_t SLOT_GPIO    = 4'd2;

    // Basic I/O register offsets.
    localparam reg_addr_t REG_LED        = 8'd0;
    localparam reg_addr_t REG_BUTTON     = 8'd1;  // Read only.
    localparam reg_addr_t REG_INT_STATUS = 8'd2;  // Write one to clear.
    localparam reg_addr_t REG_INT_ENABLE = 8'd3;

    // GPIO register offsets.
    localparam reg_addr_t GPIO_OUT_EN     = 8'd0;
    localparam reg_addr_t GPIO_OUT_SIG    = 8'd1;
    localparam reg_addr_t GPIO_IN_SIG     = 8'd2;  // Read only.
    localparam reg_addr_t GPIO_INT_STATUS = 8'd3;  // Write one to clear.
    localparam reg_addr_t GPIO_INT_ENABLE = 8'd4;

    // Bus cycles without an ack before the bridge gives up.
    localparam int ACK_TIMEOUT = 16;

    // Width of the bridge timeout counter.
    localparam int TMO_W = $clog2(ACK_TIMEOUT);

endpackage

//--- src/hba_bridge.sv
// Sole HBA master. One transfer in flight, slaves must return zero when idle, no ack ends in rsp_err.
module hba_bridge import hba_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // Host command port.
    input  logic  cmd_valid,
    input  logic  cmd_rnw,
    input  abus_t cmd_addr,
    input  dbus_t cmd_wdata,
    output logic  cmd_ready,
    // Host response port.
    output logic  rsp_valid,
    output logic  rsp_err,
    output dbus_t rsp_rdata,
    input  logic  rsp_ready,
    // HBA bus, master side.
    output logic  hba_select,
    output logic  hba_rnw,
    output abus_t hba_abus,
    output dbus_t hba_dbus,
    // Slave returns.
    input  logic  ack_basicio,
    input  logic  ack_gpio,
    input  dbus_t rdata_basicio,
    input  dbus_t rdata_gpio,
    input  logic  irq_basicio,
    input  logic  irq_gpio,
    output logic  intr
);

    bridge_state_t    state;
    bridge_state_t    state_nxt;
    logic [TMO_W-1:0] tmo_cnt;    // Bus cycles spent waiting for an ack.
    logic             ack_any;
    dbus_t            rdata_any;
    logic             accept;
    logic             tmo_hit;

    // Inactive slaves drive zero, so a plain OR merges them.
    assign ack_any   = ack_basicio | ack_gpio;
    assign rdata_any = rdata_basicio | rdata_gpio;

    assign accept  = cmd_valid & cmd_ready;  // Command handshake.
    assign tmo_hit = (state == ST_BUS) && !ack_any &&
                     (tmo_cnt == TMO_W'(ACK_TIMEOUT - 1));  // Last allowed bus cycle.

    // Interrupt merge.
    assign intr = irq_basicio | irq_gpio;

    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE: if (accept) state_nxt = ST_BUS;
            ST_BUS:  if (ack_any || tmo_hit) state_nxt = ST_RESP;
            ST_RESP: if (rsp_ready) state_nxt = ST_IDLE;  // Response taken.
            default: state_nxt = ST_IDLE;
        endcase
    end

    // Control flops. Outputs registered from the next state.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            cmd_ready  <= 1'b0;  // Rises one cycle after reset.
            hba_select <= 1'b0;
            rsp_valid  <= 1'b0;
            tmo_cnt    <= '0;
        end else begin
            state      <= state_nxt;
            cmd_ready  <= (state_nxt == ST_IDLE);
            hba_select <= (state_nxt == ST_BUS);  // Drops on the ack edge.
            rsp_valid  <= (state_nxt == ST_RESP);
            tmo_cnt    <= (state == ST_BUS) ? tmo_cnt + 1'b1 : '0;
        end
    end

    // Payload. Held stable while select or rsp_valid is up.
    always_ff @(posedge clk) begin
        if (accept) begin
            hba_rnw  <= cmd_rnw;
            hba_abus <= cmd_addr;
            hba_dbus <= cmd_wdata;
        end
        if (ack_any && state == ST_BUS) begin
            rsp_rdata <= rdata_any;  // Zero for writes.
            rsp_err   <= 1'b0;
        end else if (tmo_hit) begin
            rsp_rdata <= '0;         // Unmapped slot.
            rsp_err   <= 1'b1;
        end
    end

endmodule

//--- basicio/hba_basicio.sv
// Slot 1 LEDs and buttons. Buttons are asynchronous and interrupt only on a rising edge.
module hba_basicio import hba_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // HBA bus, slave side.
    input  logic  hba_select,
    input  logic  hba_rnw,
    input  abus_t hba_abus,
    input  dbus_t hba_dbus,
    output dbus_t hba_dbus_slave,     // Zero when not acking a read.
    output logic  hba_xferack_slave,  // One cycle per transfer.
    output logic  slave_interrupt,
    // Pins.
    input  dbus_t basicio_button,
    output dbus_t basicio_led
);

    slot_t     slot;
    reg_addr_t reg_addr;
    logic      xfer;        // This slot is addressed and not yet acked.
    logic      wr_en;
    dbus_t     btn_meta;    // First sync stage.
    dbus_t     btn_sync;    // Readable button value.
    dbus_t     btn_prev;    // History for edge detect.
    dbus_t     btn_rise;
    dbus_t     int_status;
    dbus_t     int_enable;
    dbus_t     int_clr;
    dbus_t     rd_val;

    assign slot     = hba_abus[11:8];
    assign reg_addr = hba_abus[7:0];
    assign xfer     = hba_select && (slot == SLOT_BASICIO) && !hba_xferack_slave;
    assign wr_en    = xfer && !hba_rnw;

    assign btn_rise = btn_sync & ~btn_prev;
    assign int_clr  = (wr_en && reg_addr == REG_INT_STATUS) ? hba_dbus : '0;  // W1C.

    assign slave_interrupt = |(int_status & int_enable);

    // Read mux. Unlisted offsets read zero.
    always_comb begin
        case (reg_addr)
            REG_LED:        rd_val = basicio_led;
            REG_BUTTON:     rd_val = btn_sync;
            REG_INT_STATUS: rd_val = int_status;
            REG_INT_ENABLE: rd_val = int_enable;
            default:        rd_val = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hba_xferack_slave <= 1'b0;
            hba_dbus_slave    <= '0;
            basicio_led       <= '0;
            int_enable        <= '0;
            int_status        <= '0;
            btn_meta          <= '0;
            btn_sync          <= '0;
            btn_prev          <= '0;
        end else begin
            hba_xferack_slave <= xfer;
            hba_dbus_slave    <= (xfer && hba_rnw) ? rd_val : '0;
            if (wr_en && reg_addr == REG_LED) basicio_led <= hba_dbus;
            if (wr_en && reg_addr == REG_INT_ENABLE) int_enable <= hba_dbus;
            int_status <= (int_status & ~int_clr) | btn_rise;  // New edge beats clear.
            btn_meta   <= basicio_button;
            btn_sync   <= btn_meta;
            btn_prev   <= btn_sync;
        end
    end

endmodule

//--- gpio/gpio_regs.sv
// Slot 2 GPIO registers. Inputs must arrive already synchronized, upper data bits read zero.
module gpio_regs import hba_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // HBA bus, slave side.
    input  logic  hba_select,
    input  logic  hba_rnw,
    input  abus_t hba_abus,
    input  dbus_t hba_dbus,
    output dbus_t hba_dbus_slave,     // Zero when not acking a read.
    output logic  hba_xferack_slave,
    output logic  slave_interrupt,
    // From the input synchronizer.
    input  gpio_t in_sync,
    input  gpio_t in_change,
    // Pins.
    output gpio_t gpio_out_en,
    output gpio_t gpio_out_sig
);

    slot_t     slot;
    reg_addr_t reg_addr;
    logic      xfer;
    logic      wr_en;
    gpio_t     wr_val;      // Low nibble of the write data.
    gpio_t     int_status;
    gpio_t     int_enable;
    gpio_t     int_clr;
    dbus_t     rd_val;

    assign slot     = hba_abus[11:8];
    assign reg_addr = hba_abus[7:0];
    assign xfer     = hba_select && (slot == SLOT_GPIO) && !hba_xferack_slave;
    assign wr_en    = xfer && !hba_rnw;
    assign wr_val   = gpio_t'(hba_dbus);

    // Write one to clear.
    assign int_clr = (wr_en && reg_addr == GPIO_INT_STATUS) ? wr_val : '0;

    assign slave_interrupt = |(int_status & int_enable);

    always_comb begin
        case (reg_addr)
            GPIO_OUT_EN:     rd_val = dbus_t'(gpio_out_en);
            GPIO_OUT_SIG:    rd_val = dbus_t'(gpio_out_sig);
            GPIO_IN_SIG:     rd_val = dbus_t'(in_sync);
            GPIO_INT_STATUS: rd_val = dbus_t'(int_status);
            GPIO_INT_ENABLE: rd_val = dbus_t'(int_enable);
            default:         rd_val = '0;  // Unmapped offset.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hba_xferack_slave <= 1'b0;
            hba_dbus_slave    <= '0;
            gpio_out_en       <= '0;  // All pins input after reset.
            gpio_out_sig      <= '0;
            int_enable        <= '0;
            int_status        <= '0;
        end else begin
            hba_xferack_slave <= xfer;
            hba_dbus_slave    <= (xfer && hba_rnw) ? rd_val : '0;
            if (wr_en) begin
                case (reg_addr)
                    GPIO_OUT_EN:     gpio_out_en  <= wr_val;
                    GPIO_OUT_SIG:    gpio_out_sig <= wr_val;
                    GPIO_INT_ENABLE: int_enable   <= wr_val;
                    default:         ;  // Read only or unmapped.
                endcase
            end
            int_status <= (int_status & ~int_clr) | in_change;  // Change wins.
        end
    end

endmodule

//--- gpio/gpio_input_sync.sv
// GPIO input synchronizer. Two cycles of latency, pulses narrower than a clock may be missed.
module gpio_input_sync import hba_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  gpio_t gpio_in_sig,  // Asynchronous pins.
    output gpio_t in_sync,      // Safe to read.
    output gpio_t in_change     // One-cycle pulse per edge.
);

    gpio_t in_meta;   // May go metastable.
    gpio_t in_hist;   // Previous synchronized value.

    // Any edge, either direction.
    assign in_change = in_sync ^ in_hist;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
            in_hist <= '0;
        end else begin
            in_meta <= gpio_in_sig;  // Stage one.
            in_sync <= in_meta;      // Stage two.
            in_hist <= in_sync;      // History for the change detect.
        end
    end

endmodule

//--- src/hba_system.sv
// HBA system top. Slot 1 is basic I/O, slot 2 is GPIO, and every other slot is unmapped.
module hba_system import hba_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // Host command port.
    input  logic  cmd_valid,
    input  logic  cmd_rnw,
    input  abus_t cmd_addr,
    input  dbus_t cmd_wdata,
    output logic  cmd_ready,
    // Host response port.
    input  logic  rsp_ready,
    output logic  rsp_valid,
    output dbus_t rsp_rdata,
    output logic  rsp_err,
    output logic  intr,
    // Basic I/O pins.
    input  dbus_t basicio_button,
    output dbus_t basicio_led,
    // GPIO pins.
    input  gpio_t gpio_in_sig,
    output gpio_t gpio_out_en,
    output gpio_t gpio_out_sig
);

    logic  hba_select;     // Transfer in progress.
    logic  hba_rnw;        // High for a read.
    abus_t hba_abus;
    dbus_t hba_dbus;       // Write data.
    logic  ack_basicio;
    logic  ack_gpio;
    dbus_t rdata_basicio;
    dbus_t rdata_gpio;
    logic  irq_basicio;
    logic  irq_gpio;
    gpio_t gpio_in_sync;   // Synchronized pins.
    gpio_t gpio_in_change;

    hba_bridge i_bridge (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_rnw(cmd_rnw), .cmd_addr(cmd_addr),
        .cmd_wdata(cmd_wdata), .cmd_ready(cmd_ready),
        .rsp_valid(rsp_valid), .rsp_err(rsp_err), .rsp_rdata(rsp_rdata),
        .rsp_ready(rsp_ready),
        .hba_select(hba_select), .hba_rnw(hba_rnw), .hba_abus(hba_abus),
        .hba_dbus(hba_dbus),
        .ack_basicio(ack_basicio), .ack_gpio(ack_gpio),
        .rdata_basicio(rdata_basicio), .rdata_gpio(rdata_gpio),
        .irq_basicio(irq_basicio), .irq_gpio(irq_gpio), .intr(intr)
    );

    hba_basicio i_basicio (
        .clk(clk), .rst_n(rst_n),
        .hba_select(hba_select), .hba_rnw(hba_rnw), .hba_abus(hba_abus),
        .hba_dbus(hba_dbus), .hba_dbus_slave(rdata_basicio),
        .hba_xferack_slave(ack_basicio), .slave_interrupt(irq_basicio),
        .basicio_button(basicio_button), .basicio_led(basicio_led)
    );

    gpio_regs i_gpio_regs (
        .clk(clk), .rst_n(rst_n),
        .hba_select(hba_select), .hba_rnw(hba_rnw), .hba_abus(hba_abus),
        .hba_dbus(hba_dbus), .hba_dbus_slave(rdata_gpio),
        .hba_xferack_slave(ack_gpio), .slave_interrupt(irq_gpio),
        .in_sync(gpio_in_sync), .in_change(gpio_in_change),
        .gpio_out_en(gpio_out_en), .gpio_out_sig(gpio_out_sig)
    );

    gpio_input_sync i_gpio_sync (
        .clk(clk), .rst_n(rst_n), .gpio_in_sig(gpio_in_sig),
        .in_sync(gpio_in_sync), .in_change(gpio_in_change)
    );

endmodule

//--- dv/hba_system_tb.sv
// Directed HBA system testbench. Stops at the first mismatch and reads no input files.
module hba_system_tb import hba_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_XFERS  = 22;  // Host transfers issued by all tests.
    localparam int MAX_CYCLES = NUM_XFERS * (ACK_TIMEOUT + 8) + 16 + 64;  // Plus reset and settling.

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_rnw;
    abus_t       cmd_addr;
    dbus_t       cmd_wdata;
    logic        cmd_ready;
    logic        rsp_ready;
    logic        rsp_valid;
    dbus_t       rsp_rdata;
    logic        rsp_err;
    logic        intr;
    dbus_t       basicio_button;
    dbus_t       basicio_led;
    gpio_t       gpio_in_sig;
    gpio_t       gpio_out_en;
    gpio_t       gpio_out_sig;
    logic [15:0] lfsr_q = 16'd6704;  // Stimulus LFSR state.
    int          cycle_cnt = 0;
    dbus_t       led_val;            // Last value written to the LED register.

    hba_system i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    // Watchdog.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // Galois LFSR. One step per bit taken.
    function automatic dbus_t next_bits(input int n);
        dbus_t val;
        logic  lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb    = lfsr_q[0];
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lsb ? 16'hB400 : 16'h0000);
            val    = {val[6:0], lsb};
        end
        return val;
    endfunction

    function automatic abus_t make_addr(input slot_t slot, input reg_addr_t offset);
        return {slot, offset};
    endfunction

    task automatic check_value(input string name, input dbus_t got, input dbus_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // One host command. hold is the number of cycles rsp_ready stays low.
    task automatic transfer(input logic rnw, input abus_t addr, input dbus_t wdata,
                            input int hold, output dbus_t rdata, output logic err);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_rnw   = rnw;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        rsp_ready = (hold == 0);
        while (!cmd_ready) @(negedge clk);
        @(negedge clk);  // Taken on the edge just passed.
        cmd_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        rdata = rsp_rdata;
        err   = rsp_err;
        for (int i = 0; i < hold; i++) begin
            check_value("cmd_ready", dbus_t'(cmd_ready), 8'h00);
            @(negedge clk);
            check_value("rsp_valid", dbus_t'(rsp_valid), 8'h01);  // Held under back-pressure.
            check_value("rsp_rdata", rsp_rdata, rdata);
            check_value("rsp_err", dbus_t'(rsp_err), dbus_t'(err));
        end
        if (hold > 0) check_value("cmd_ready", dbus_t'(cmd_ready), 8'h00);  // Last held cycle.
        rsp_ready = 1'b1;  // Handshake on the next edge.
    endtask

    task automatic bus_write(input abus_t addr, input dbus_t data);
        dbus_t rd;
        logic  err;
        transfer(1'b0, addr, data, 0, rd, err);
        check_value("rsp_err", dbus_t'(err), 8'h00);
    endtask

    task automatic bus_read(input abus_t addr, output dbus_t data, output logic err);
        transfer(1'b1, addr, 8'h00, 0, data, err);
    endtask

    task automatic expect_read(input abus_t addr, input dbus_t exp);
        dbus_t rd;
        logic  err;
        bus_read(addr, rd, err);
        check_value("rsp_rdata", rd, exp);
        check_value("rsp_err", dbus_t'(err), 8'h00);
    endtask

    task automatic reset_state();
        check_value("cmd_ready", dbus_t'(cmd_ready), 8'h00);  // Still in reset.
        check_value("rsp_valid", dbus_t'(rsp_valid), 8'h00);
        check_value("intr", dbus_t'(intr), 8'h00);
        check_value("basicio_led", basicio_led, 8'h00);
        check_value("gpio_out_en", dbus_t'(gpio_out_en), 8'h00);
        check_value("gpio_out_sig", dbus_t'(gpio_out_sig), 8'h00);
        rst_n = 1'b1;
        while (!cmd_ready) @(negedge clk);
    endtask

    task automatic write_readback();
        dbus_t oe;
        dbus_t sig;
        led_val = next_bits(8);
        oe      = next_bits(8);
        sig     = next_bits(8);
        bus_write(make_addr(SLOT_BASICIO, REG_LED), led_val);
        expect_read(make_addr(SLOT_BASICIO, REG_LED), led_val);
        check_value("basicio_led", basicio_led, led_val);
        bus_write(make_addr(SLOT_GPIO, GPIO_OUT_EN), oe);
        expect_read(make_addr(SLOT_GPIO, GPIO_OUT_EN), oe & 8'h0F);  // Upper nibble reads zero.
        check_value("gpio_out_en", dbus_t'(gpio_out_en), oe & 8'h0F);
        bus_write(make_addr(SLOT_GPIO, GPIO_OUT_SIG), sig);
        expect_read(make_addr(SLOT_GPIO, GPIO_OUT_SIG), sig & 8'h0F);
        check_value("gpio_out_sig", dbus_t'(gpio_out_sig), sig & 8'h0F);
    endtask

    task automatic input_readback();
        dbus_t btn;
        gpio_t pins;
        btn  = next_bits(8);
        pins = gpio_t'(next_bits(4));
        @(negedge clk);
        basicio_button = btn;
        gpio_in_sig    = pins;
        wait_cycles(3);  // Past the two sync stages.
        expect_read(make_addr(SLOT_BASICIO, REG_BUTTON), btn);
        expect_read(make_addr(SLOT_GPIO, GPIO_IN_SIG), dbus_t'(pins));
    endtask

    task automatic interrupts();
        int b;
        int g;
        b = int'(next_bits(3));
        g = int'(next_bits(2));
        @(negedge clk);
        basicio_button = 8'h00;  // Falling edges set nothing.
        wait_cycles(4);
        bus_write(make_addr(SLOT_BASICIO, REG_INT_STATUS), 8'hFF);  // Old edges out.
        bus_write(make_addr(SLOT_GPIO, GPIO_INT_STATUS), 8'h0F);
        bus_write(make_addr(SLOT_BASICIO, REG_INT_ENABLE), 8'hFF);
        check_value("intr", dbus_t'(intr), 8'h00);
        @(negedge clk);
        basicio_button = 8'h01 << b;
        wait_cycles(4);  // Sync, then status.
        check_value("intr", dbus_t'(intr), 8'h01);
        expect_read(make_addr(SLOT_BASICIO, REG_INT_STATUS), 8'h01 << b);
        bus_write(make_addr(SLOT_BASICIO, REG_INT_STATUS), 8'h01 << b);
        check_value("intr", dbus_t'(intr), 8'h00);
        bus_write(make_addr(SLOT_GPIO, GPIO_INT_ENABLE), 8'h01 << g);
        @(negedge clk);
        gpio_in_sig = gpio_in_sig ^ gpio_t'(4'h1 << g);  // Either edge counts.
        wait_cycles(4);
        check_value("intr", dbus_t'(intr), 8'h01);
        expect_read(make_addr(SLOT_GPIO, GPIO_INT_STATUS), 8'h01 << g);
        bus_write(make_addr(SLOT_GPIO, GPIO_INT_STATUS), 8'h01 << g);
        check_value("intr", dbus_t'(intr), 8'h00);
    endtask

    task automatic unmapped_access();
        dbus_t rd;
        logic  err;
        bus_read(make_addr(4'd5, 8'h00), rd, err);  // No slave in slot 5.
        check_value("rsp_err", dbus_t'(err), 8'h01);
        check_value("rsp_rdata", rd, 8'h00);
        expect_read(make_addr(SLOT_BASICIO, 8'd7), 8'h00);
        bus_write(make_addr(SLOT_BASICIO, 8'd7), next_bits(8));
        expect_read(make_addr(SLOT_BASICIO, REG_LED), led_val);
        expect_read(make_addr(SLOT_BASICIO, REG_INT_ENABLE), 8'hFF);
    endtask

    task automatic back_pressure();
        dbus_t rd;
        logic  err;
        int    hold;
        hold = 1 + int'(next_bits(3));
        transfer(1'b1, make_addr(SLOT_BASICIO, REG_LED), 8'h00, hold, rd, err);
        check_value("rsp_rdata", rd, led_val);
        check_value("rsp_err", dbus_t'(err), 8'h00);
    endtask

    initial begin
        rst_n          = 1'b0;
        cmd_valid      = 1'b0;
        cmd_rnw        = 1'b0;
        cmd_addr       = '0;
        cmd_wdata      = '0;
        rsp_ready      = 1'b1;
        basicio_button = '0;
        gpio_in_sig    = '0;
        repeat (16) @(negedge clk);
        reset_state();
        write_readback();
        input_readback();
        interrupts();
        unmapped_access();
        back_pressure();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- hba_system.f
common/hba_pkg.sv
src/hba_bridge.sv
basicio/hba_basicio.sv
gpio/gpio_regs.sv
gpio/gpio_input_sync.sv
src/hba_system.sv
dv/hba_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the HBA system testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module hba_system_tb \
    -f hba_system.f -o hba_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/hba_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0
